//--- verilog/bp_cfg_pkg.sv
// table sizes and index geometry for the branch predictors, imported by all frontend RTL
`default_nettype none

package bp_cfg_pkg;

    // ------------------------------------------------------------------------
    // address geometry
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN      = 64;  // virtual address width
    localparam int unsigned PC_OFFSET = 2;   // pc always steps by 4, low bits never index

    // ------------------------------------------------------------------------
    // table sizes
    // ------------------------------------------------------------------------
    localparam int unsigned BTB_ENTRIES = 8;   // direct mapped, no tags
    localparam int unsigned BHT_ENTRIES = 32;  // one 2-bit counter each
    localparam int unsigned RAS_DEPTH   = 2;   // shallow return stack

    // index widths follow from the entry counts
    localparam int unsigned BTB_IDX_W = $clog2(BTB_ENTRIES);
    localparam int unsigned BHT_IDX_W = $clog2(BHT_ENTRIES);

endpackage

`default_nettype wire

//--- verilog/bp_types_pkg.sv
// vector types and enums shared by the fetch PC generator and the prediction tables
`default_nettype none

package bp_types_pkg;

    import bp_cfg_pkg::*;

    // ------------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------------
    typedef logic [XLEN-1:0]      addr_t;     // fetch pc or branch target
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;  // btb entry select
    typedef logic [BHT_IDX_W-1:0] bht_idx_t;  // bht entry select
    typedef logic [1:0]           sat_ctr_t;  // 0,1 not taken / 2,3 taken

    // ------------------------------------------------------------------------
    // enums
    // ------------------------------------------------------------------------
    // kind of the acknowledged instruction, reported by the backend
    typedef enum logic [1:0] {
        KIND_OTHER  = 2'd0,
        KIND_BRANCH = 2'd1,  // conditional branch
        KIND_CALL   = 2'd2,  // jal/jalr writing ra
        KIND_RET    = 2'd3   // jalr through ra
    } instr_kind_e;

    // fetch FSM, idle until the first enable
    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_RUN  = 1'b1
    } fetch_state_e;

endpackage

`default_nettype wire

//--- verilog/btb.sv
// direct-mapped branch target buffer, read by the fetch pc and written by resolved branches
`default_nettype none

module btb (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 flush_i,          // drop every entry
    input  wire bp_types_pkg::addr_t  lookup_pc_i,      // current fetch pc
    input  wire logic                 upd_valid_i,      // resolve strobe
    input  wire bp_types_pkg::addr_t  upd_pc_i,
    input  wire bp_types_pkg::addr_t  upd_target_i,
    input  wire logic                 upd_taken_i,
    input  wire logic                 upd_is_branch_i,
    output logic                      hit_o,
    output bp_types_pkg::addr_t       target_o
);

    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    logic [BTB_ENTRIES-1:0] valid_q;                // cleared by reset and flush
    addr_t                  target_q [BTB_ENTRIES]; // payload only
    btb_idx_t               lookup_idx;
    btb_idx_t               upd_idx;
    logic                   do_write;
    logic                   do_clear;

    assign lookup_idx = lookup_pc_i[PC_OFFSET +: BTB_IDX_W];
    assign upd_idx    = upd_pc_i[PC_OFFSET +: BTB_IDX_W];

    // lookup straight from the registered entries
    assign hit_o    = valid_q[lookup_idx];
    assign target_o = target_q[lookup_idx];

    // taken resolve installs the target
    assign do_write = upd_valid_i && upd_taken_i;
    // not taken and not a branch, so the entry aliased onto something else
    assign do_clear = upd_valid_i && !upd_taken_i && !upd_is_branch_i;

    // ------------------------------------------------------------------------
    // valid bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;                   // flush wins over any update
        end else if (do_write) begin
            valid_q[upd_idx] <= 1'b1;
        end else if (do_clear) begin
            valid_q[upd_idx] <= 1'b0;
        end
    end

    // targets
    always_ff @(posedge clk_i) begin
        if (do_write && !flush_i) begin
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bht.sv
// branch history table of 2-bit saturating counters, trained by resolved conditional branches
`default_nettype none

module bht (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 flush_i,          // clears valid bits only
    input  wire bp_types_pkg::addr_t  lookup_pc_i,
    input  wire logic                 upd_valid_i,
    input  wire bp_types_pkg::addr_t  upd_pc_i,
    input  wire logic                 upd_is_branch_i,
    input  wire logic                 upd_taken_i,
    output logic                      valid_o,
    output logic                      taken_o
);

    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    logic [BHT_ENTRIES-1:0] valid_q;
    sat_ctr_t               ctr_q [BHT_ENTRIES];
    sat_ctr_t               ctr_cur;             // counter at the update index
    sat_ctr_t               ctr_nxt;
    bht_idx_t               lookup_idx;
    bht_idx_t               upd_idx;
    logic                   train;

    assign lookup_idx = lookup_pc_i[PC_OFFSET +: BHT_IDX_W];
    assign upd_idx    = upd_pc_i[PC_OFFSET +: BHT_IDX_W];

    assign valid_o = valid_q[lookup_idx];
    assign taken_o = ctr_q[lookup_idx][1];       // upper bit is the prediction

    // only conditional branches move the counters
    assign train   = upd_valid_i && upd_is_branch_i;
    assign ctr_cur = ctr_q[upd_idx];

    // ------------------------------------------------------------------------
    // saturating step
    // ------------------------------------------------------------------------
    always_comb begin
        ctr_nxt = ctr_cur;                           // hold at the bounds
        if (upd_taken_i && ctr_cur != 2'b11) begin
            ctr_nxt = ctr_cur + 2'd1;
        end else if (!upd_taken_i && ctr_cur != 2'b00) begin
            ctr_nxt = ctr_cur - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_q[i] <= 2'b00;                   // start strongly not taken
            end
        end else if (flush_i) begin
            valid_q <= '0;                           // counters survive a flush
        end else if (train) begin
            valid_q[upd_idx] <= 1'b1;
            ctr_q[upd_idx]   <= ctr_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ras.sv
// return address stack as a shift register, top entry at index 0, oldest entry dropped on overflow
`default_nettype none

module ras (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 push_i,     // never together with pop_i
    input  wire logic                 pop_i,
    input  wire bp_types_pkg::addr_t  data_i,     // return address to push
    output logic                      valid_o,
    output bp_types_pkg::addr_t       addr_o
);

    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    logic [RAS_DEPTH-1:0] valid_q;
    addr_t                addr_q [RAS_DEPTH];

    assign valid_o = valid_q[0];
    assign addr_o  = addr_q[0];

    // ------------------------------------------------------------------------
    // valid bits
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (push_i) begin
            valid_q <= {valid_q[RAS_DEPTH-2:0], 1'b1};  // bottom falls off
        end else if (pop_i) begin
            valid_q <= {1'b0, valid_q[RAS_DEPTH-1:1]};  // bottom freed
        end
    end

    // addresses move with their valid bits
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            addr_q[0] <= data_i;
            for (int i = 1; i < RAS_DEPTH; i++) begin
                addr_q[i] <= addr_q[i-1];
            end
        end else if (pop_i) begin
            for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                addr_q[i] <= addr_q[i+1];
            end
            addr_q[RAS_DEPTH-1] <= '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pc_gen.sv
// fetch pc generator that picks the next pc from a backend redirect, the predictors or pc+4
`default_nettype none

module pc_gen (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       fetch_enable_i,  // start fetching
    input  wire bp_types_pkg::addr_t        boot_addr_i,
    input  wire logic                       fetch_ack_i,     // backend took the instruction
    input  wire bp_types_pkg::instr_kind_e  instr_kind_i,
    input  wire logic                       resolve_valid_i,
    input  wire logic                       resolve_mispredict_i,
    input  wire logic                       resolve_taken_i,
    input  wire bp_types_pkg::addr_t        resolve_pc_i,
    input  wire bp_types_pkg::addr_t        resolve_target_i,
    input  wire logic                       btb_hit_i,
    input  wire bp_types_pkg::addr_t        btb_target_i,
    input  wire logic                       bht_valid_i,
    input  wire logic                       bht_taken_i,
    input  wire logic                       ras_valid_i,
    input  wire bp_types_pkg::addr_t        ras_addr_i,
    output bp_types_pkg::addr_t             fetch_pc_o,
    output logic                            fetch_valid_o,
    output logic                            pred_taken_o,
    output bp_types_pkg::addr_t             pred_target_o,
    output logic                            ras_push_o,
    output logic                            ras_pop_o,
    output bp_types_pkg::addr_t             ras_data_o
);

    import bp_types_pkg::*;

    fetch_state_e state_q;
    addr_t        pc_q;
    addr_t        pc_seq;      // sequential successor
    addr_t        pc_nxt;
    logic         redirect;    // backend mispredict overrides everything
    logic         advance;     // ack consumed with stack side effects

    assign pc_seq        = pc_q + addr_t'(4);
    assign redirect      = resolve_valid_i && resolve_mispredict_i;
    assign advance       = (state_q == FETCH_RUN) && fetch_ack_i && !redirect;
    assign fetch_pc_o    = pc_q;
    assign fetch_valid_o = (state_q == FETCH_RUN);

    // ------------------------------------------------------------------------
    // prediction for the current pc and instruction kind
    // ------------------------------------------------------------------------
    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = pc_seq;                         // fall through
        case (instr_kind_i)
            KIND_RET: if (ras_valid_i) begin
                pred_taken_o  = 1'b1;
                pred_target_o = ras_addr_i;
            end
            KIND_CALL: if (btb_hit_i) begin
                pred_taken_o  = 1'b1;
                pred_target_o = btb_target_i;
            end
            KIND_BRANCH: if (btb_hit_i && bht_valid_i && bht_taken_i) begin
                pred_taken_o  = 1'b1;
                pred_target_o = btb_target_i;
            end
            default: ;
        endcase
    end

    // stack moves only on a predicted call or return that really advances
    assign ras_push_o = advance && (instr_kind_i == KIND_CALL) && btb_hit_i;
    assign ras_pop_o  = advance && (instr_kind_i == KIND_RET) && ras_valid_i;
    assign ras_data_o = pc_seq;                          // link address

    always_comb begin
        if (redirect) begin
            pc_nxt = resolve_taken_i ? resolve_target_i : resolve_pc_i + addr_t'(4);
        end else if (fetch_ack_i) begin
            pc_nxt = pred_target_o;
        end else begin
            pc_nxt = pc_q;                               // back-pressure, hold
        end
    end

    // ------------------------------------------------------------------------
    // fetch FSM and pc register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FETCH_IDLE;
            pc_q    <= '0;
        end else begin
            case (state_q)
                FETCH_IDLE: if (fetch_enable_i) begin
                    state_q <= FETCH_RUN;                // stays here from now on
                    pc_q    <= boot_addr_i;
                end
                default: pc_q <= pc_nxt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/branch_frontend.sv
// branch prediction frontend top, pc generator wired to the btb, bht and return stack
`default_nettype none

module branch_frontend (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire logic                       flush_bp_i,      // invalidate btb and bht
    input  wire logic                       fetch_enable_i,
    input  wire bp_types_pkg::addr_t        boot_addr_i,
    input  wire logic                       fetch_ack_i,
    input  wire bp_types_pkg::instr_kind_e  instr_kind_i,
    input  wire logic                       resolve_valid_i,
    input  wire logic                       resolve_taken_i,
    input  wire logic                       resolve_is_branch_i,
    input  wire logic                       resolve_mispredict_i,
    input  wire bp_types_pkg::addr_t        resolve_pc_i,
    input  wire bp_types_pkg::addr_t        resolve_target_i,
    output bp_types_pkg::addr_t             fetch_pc_o,
    output logic                            fetch_valid_o,
    output logic                            pred_taken_o,
    output bp_types_pkg::addr_t             pred_target_o
);

    import bp_types_pkg::*;

    logic  btb_hit;
    addr_t btb_target;
    logic  bht_valid;
    logic  bht_taken;
    logic  ras_push;
    logic  ras_pop;
    addr_t ras_data;
    logic  ras_valid;
    addr_t ras_addr;

    // ------------------------------------------------------------------------
    // next pc selection
    // ------------------------------------------------------------------------
    pc_gen i_pc_gen (
        .clk_i                ( clk_i                ),
        .rst_ni               ( rst_ni               ),
        .fetch_enable_i       ( fetch_enable_i       ),
        .boot_addr_i          ( boot_addr_i          ),
        .fetch_ack_i          ( fetch_ack_i          ),
        .instr_kind_i         ( instr_kind_i         ),
        .resolve_valid_i      ( resolve_valid_i      ),
        .resolve_mispredict_i ( resolve_mispredict_i ),
        .resolve_taken_i      ( resolve_taken_i      ),
        .resolve_pc_i         ( resolve_pc_i         ),
        .resolve_target_i     ( resolve_target_i     ),
        .btb_hit_i            ( btb_hit              ),
        .btb_target_i         ( btb_target           ),
        .bht_valid_i          ( bht_valid            ),
        .bht_taken_i          ( bht_taken            ),
        .ras_valid_i          ( ras_valid            ),
        .ras_addr_i           ( ras_addr             ),
        .fetch_pc_o           ( fetch_pc_o           ),  // also the table lookup pc
        .fetch_valid_o        ( fetch_valid_o        ),
        .pred_taken_o         ( pred_taken_o         ),
        .pred_target_o        ( pred_target_o        ),
        .ras_push_o           ( ras_push             ),
        .ras_pop_o            ( ras_pop              ),
        .ras_data_o           ( ras_data             )
    );

    // ------------------------------------------------------------------------
    // predictors
    // ------------------------------------------------------------------------
    btb i_btb (
        .clk_i           ( clk_i               ),
        .rst_ni          ( rst_ni              ),
        .flush_i         ( flush_bp_i          ),
        .lookup_pc_i     ( fetch_pc_o          ),
        .upd_valid_i     ( resolve_valid_i     ),
        .upd_pc_i        ( resolve_pc_i        ),
        .upd_target_i    ( resolve_target_i    ),
        .upd_taken_i     ( resolve_taken_i     ),
        .upd_is_branch_i ( resolve_is_branch_i ),
        .hit_o           ( btb_hit             ),
        .target_o        ( btb_target          )
    );

    bht i_bht (
        .clk_i           ( clk_i               ),
        .rst_ni          ( rst_ni              ),
        .flush_i         ( flush_bp_i          ),
        .lookup_pc_i     ( fetch_pc_o          ),
        .upd_valid_i     ( resolve_valid_i     ),
        .upd_pc_i        ( resolve_pc_i        ),
        .upd_is_branch_i ( resolve_is_branch_i ),
        .upd_taken_i     ( resolve_taken_i     ),
        .valid_o         ( bht_valid           ),
        .taken_o         ( bht_taken           )
    );

    ras i_ras (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .push_i  ( ras_push  ),
        .pop_i   ( ras_pop   ),
        .data_i  ( ras_data  ),
        .valid_o ( ras_valid ),
        .addr_o  ( ras_addr  )
    );

endmodule

`default_nettype wire

//--- testbench/tb_branch_frontend.sv
// randomized testbench for branch_frontend, checked every cycle against a model of the tables and pc
`default_nettype none

module tb_branch_frontend;

    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    localparam addr_t BOOT_ADDR  = 64'h0000_0000_8000_1000;
    localparam int    NUM_CYCLES = 3000;  // full random mix
    localparam int    WAIT_LIMIT = 20;    // cycles allowed for fetch_valid_o

    // dut inputs
    logic        clk_i;
    logic        rst_ni;
    logic        flush_bp_i;
    logic        fetch_enable_i;
    addr_t       boot_addr_i;
    logic        fetch_ack_i;
    instr_kind_e instr_kind_i;
    logic        resolve_valid_i;
    logic        resolve_taken_i;
    logic        resolve_is_branch_i;
    logic        resolve_mispredict_i;
    addr_t       resolve_pc_i;
    addr_t       resolve_target_i;
    // dut outputs
    addr_t       fetch_pc_o;
    logic        fetch_valid_o;
    logic        pred_taken_o;
    addr_t       pred_target_o;

    // reference model state
    logic        m_run;                 // fetch FSM left idle
    addr_t       m_pc;
    logic        m_btb_v [BTB_ENTRIES];
    addr_t       m_btb_t [BTB_ENTRIES];
    logic        m_bht_v [BHT_ENTRIES];
    int          m_bht_c [BHT_ENTRIES]; // counter value 0..3
    logic        m_ras_v [RAS_DEPTH];   // index 0 is the top
    addr_t       m_ras_a [RAS_DEPTH];

    int          errors = 0;
    int          checks = 0;
    logic        timed_out = 1'b0;

    branch_frontend i_branch_frontend (
        .clk_i                ( clk_i                ),
        .rst_ni               ( rst_ni               ),
        .flush_bp_i           ( flush_bp_i           ),
        .fetch_enable_i       ( fetch_enable_i       ),
        .boot_addr_i          ( boot_addr_i          ),
        .fetch_ack_i          ( fetch_ack_i          ),
        .instr_kind_i         ( instr_kind_i         ),
        .resolve_valid_i      ( resolve_valid_i      ),
        .resolve_taken_i      ( resolve_taken_i      ),
        .resolve_is_branch_i  ( resolve_is_branch_i  ),
        .resolve_mispredict_i ( resolve_mispredict_i ),
        .resolve_pc_i         ( resolve_pc_i         ),
        .resolve_target_i     ( resolve_target_i     ),
        .fetch_pc_o           ( fetch_pc_o           ),
        .fetch_valid_o        ( fetch_valid_o        ),
        .pred_taken_o         ( pred_taken_o         ),
        .pred_target_o        ( pred_target_o        )
    );

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // model helpers
    // ------------------------------------------------------------------------
    function automatic int btb_index(input addr_t pc);
        return int'((pc >> PC_OFFSET) % BTB_ENTRIES);  // word index, wrapped
    endfunction

    function automatic int bht_index(input addr_t pc);
        return int'((pc >> PC_OFFSET) % BHT_ENTRIES);
    endfunction

    // expected prediction for the model pc and the kind on the inputs
    task automatic predict(output logic taken, output addr_t target);
        int bi;
        int hi;
        bi     = btb_index(m_pc);
        hi     = bht_index(m_pc);
        taken  = 1'b0;
        target = m_pc + 64'd4;
        if (instr_kind_i == KIND_RET && m_ras_v[0]) begin
            taken  = 1'b1;
            target = m_ras_a[0];
        end else if (instr_kind_i == KIND_CALL && m_btb_v[bi]) begin
            taken  = 1'b1;
            target = m_btb_t[bi];
        end else if (instr_kind_i == KIND_BRANCH && m_btb_v[bi] && m_bht_v[hi]
                     && m_bht_c[hi] >= 2) begin
            taken  = 1'b1;                          // weakly or strongly taken
            target = m_btb_t[bi];
        end
    endtask

    always @(posedge clk_i or negedge rst_ni) begin : ref_model
        logic  p_taken;
        addr_t p_target;
        int    bi;
        int    hi;
        if (!rst_ni) begin
            m_run = 1'b0;
            m_pc  = '0;
            foreach (m_btb_v[i]) m_btb_v[i] = 1'b0;
            foreach (m_bht_v[i]) begin
                m_bht_v[i] = 1'b0;
                m_bht_c[i] = 0;
            end
            foreach (m_ras_v[i]) m_ras_v[i] = 1'b0;
        end else begin
            predict(p_taken, p_target);             // tables before this edge
            if (!m_run) begin
                if (fetch_enable_i) begin
                    m_run = 1'b1;
                    m_pc  = boot_addr_i;
                end
            end else if (resolve_valid_i && resolve_mispredict_i) begin
                m_pc = resolve_taken_i ? resolve_target_i : resolve_pc_i + 64'd4;
            end else if (fetch_ack_i) begin
                if (instr_kind_i == KIND_CALL && p_taken) begin
                    m_ras_v[1] = m_ras_v[0];        // oldest falls off
                    m_ras_a[1] = m_ras_a[0];
                    m_ras_v[0] = 1'b1;
                    m_ras_a[0] = m_pc + 64'd4;
                end else if (instr_kind_i == KIND_RET && p_taken) begin
                    m_ras_v[0] = m_ras_v[1];
                    m_ras_a[0] = m_ras_a[1];
                    m_ras_v[1] = 1'b0;
                end
                m_pc = p_target;
            end
            // table training
            bi = btb_index(resolve_pc_i);
            hi = bht_index(resolve_pc_i);
            if (flush_bp_i) begin
                foreach (m_btb_v[i]) m_btb_v[i] = 1'b0;
                foreach (m_bht_v[i]) m_bht_v[i] = 1'b0;  // counters kept
            end else if (resolve_valid_i) begin
                if (resolve_taken_i) begin
                    m_btb_v[bi] = 1'b1;
                    m_btb_t[bi] = resolve_target_i;
                end else if (!resolve_is_branch_i) begin
                    m_btb_v[bi] = 1'b0;             // aliased entry
                end
                if (resolve_is_branch_i) begin
                    m_bht_v[hi] = 1'b1;
                    if (resolve_taken_i && m_bht_c[hi] < 3) m_bht_c[hi]++;
                    if (!resolve_taken_i && m_bht_c[hi] > 0) m_bht_c[hi]--;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // checking and stimulus
    // ------------------------------------------------------------------------
    task automatic report_mismatch(input string what, input addr_t got, input addr_t exp);
        errors++;
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic compare_outputs();
        logic  p_taken;
        addr_t p_target;
        checks++;
        assert (fetch_valid_o === m_run)
        else report_mismatch("fetch_valid_o", addr_t'(fetch_valid_o), addr_t'(m_run));
        if (m_run) begin                              // pc is meaningless while idle
            predict(p_taken, p_target);
            assert (fetch_pc_o === m_pc)
            else report_mismatch("fetch_pc_o", fetch_pc_o, m_pc);
            assert (pred_taken_o === p_taken)
            else report_mismatch("pred_taken_o", addr_t'(pred_taken_o), addr_t'(p_taken));
            assert (pred_target_o === p_target)
            else report_mismatch("pred_target_o", pred_target_o, p_target);
        end
    endtask

    // small pool of word addresses, 16 of them alias onto 8 btb entries
    function automatic addr_t pick_addr();
        return BOOT_ADDR + addr_t'(4 * ($urandom % 16));
    endfunction

    task automatic drive_random(input logic full_mix);
        int k;
        k           = $urandom % 100;
        fetch_ack_i = ($urandom % 4) != 0;          // some back-pressure
        if (k < 30)      instr_kind_i = KIND_CALL;
        else if (k < 60) instr_kind_i = KIND_RET;
        else if (k < 85) instr_kind_i = KIND_BRANCH;
        else             instr_kind_i = KIND_OTHER;
        resolve_valid_i      = full_mix && (($urandom % 2) == 1);
        resolve_pc_i         = (($urandom % 2) == 1) ? m_pc : pick_addr();
        resolve_target_i     = pick_addr();
        resolve_taken_i      = ($urandom % 2) == 1;
        resolve_is_branch_i  = ($urandom % 2) == 1;
        resolve_mispredict_i = ($urandom % 8) == 0;  // pulls fetch back into the pool
        flush_bp_i           = full_mix && (($urandom % 40) == 0);
    endtask

    // outputs are sampled well after the rising edge, inputs change on the falling one
    task automatic run_cycle(input logic full_mix);
        @(posedge clk_i);
        #4;
        compare_outputs();
        @(negedge clk_i);
        drive_random(full_mix);
    endtask

    initial begin : stimulus
        int waited;
        void'($urandom(88));
        clk_i                = 1'b0;
        rst_ni               = 1'b0;
        flush_bp_i           = 1'b0;
        fetch_enable_i       = 1'b0;
        boot_addr_i          = BOOT_ADDR;
        fetch_ack_i          = 1'b0;
        instr_kind_i         = KIND_OTHER;
        resolve_valid_i      = 1'b0;
        resolve_taken_i      = 1'b0;
        resolve_is_branch_i  = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_pc_i         = '0;
        resolve_target_i     = '0;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (5) run_cycle(1'b0);                 // still idle, fetch_valid_o low
        fetch_enable_i = 1'b1;
        waited         = 0;
        while (fetch_valid_o !== 1'b1 && waited < WAIT_LIMIT) begin
            run_cycle(1'b0);
            waited++;
        end
        if (fetch_valid_o !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: fetch_valid_o did not rise after fetch_enable_i");
        end
        if (!timed_out) begin
            assert (fetch_pc_o === BOOT_ADDR)
            else report_mismatch("boot fetch_pc_o", fetch_pc_o, BOOT_ADDR);
            repeat (30) run_cycle(1'b0);            // empty tables, plain pc+4 steps
            repeat (NUM_CYCLES) run_cycle(1'b1);
        end
        $display("%0d cycles checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/bp_cfg_pkg.sv
verilog/bp_types_pkg.sv
verilog/btb.sv
verilog/bht.sv
verilog/ras.sv
verilog/pc_gen.sv
verilog/branch_frontend.sv
testbench/tb_branch_frontend.sv

//--- Makefile
# Verilator build for the branch prediction frontend
TOP := tb_branch_frontend

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
